// ==== include/dmem_cfg.svh ====
`ifndef DMEM_CFG_SVH
`define DMEM_CFG_SVH

// Byte address and data word
`define DMEM_ADDR_W 32
`define DMEM_WORD_W 32

// Direct-mapped geometry, in words per line and number of lines
`define DMEM_LINE_WORDS 4
`define DMEM_LINES 16

// Pending stores held ahead of memory
`define DMEM_SB_DEPTH 4

// Destination register number
`define DMEM_REG_W 5

`endif

// ==== rtl/dmem_types_pkg.sv ====
`include "dmem_cfg.svh"

package dmem_types_pkg;

    // Address split: tag | index | word offset | byte offset
    localparam int BYTE_OFF_W = 2;
    localparam int OFFSET_W = $clog2(`DMEM_LINE_WORDS);
    localparam int INDEX_W = $clog2(`DMEM_LINES);
    localparam int TAG_W = `DMEM_ADDR_W - INDEX_W - OFFSET_W - BYTE_OFF_W;

    typedef logic [`DMEM_ADDR_W-1:0] addr_t;
    typedef logic [`DMEM_WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [`DMEM_REG_W-1:0] reg_t;

endpackage

// ==== rtl/dmem_ctrl_pkg.sv ====
package dmem_ctrl_pkg;

    typedef enum logic [1:0] {
        TL_IDLE,
        TL_MISS_WAIT,
        TL_SB_FULL
    } tl_state_e;

    typedef enum logic [1:0] {
        MU_IDLE,
        MU_DRAIN,
        MU_FILL
    } mu_state_e;

endpackage

// ==== rtl/dcache_array.sv ====
`timescale 1ns/10ps
`include "dmem_cfg.svh"

module dcache_array (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  dmem_types_pkg::index_t   lookup_index_i,
    input  dmem_types_pkg::tag_t     lookup_tag_i,
    input  dmem_types_pkg::offset_t  lookup_offset_i,
    output logic                     hit_o,
    output dmem_types_pkg::word_t    rdata_o,
    input  logic                     upd_we_i,
    input  dmem_types_pkg::word_t    upd_data_i,
    input  logic                     fill_we_i,
    input  dmem_types_pkg::index_t   fill_index_i,
    input  dmem_types_pkg::tag_t     fill_tag_i,
    input  dmem_types_pkg::offset_t  fill_offset_i,
    input  dmem_types_pkg::word_t    fill_data_i,
    input  logic                     fill_last_i
);
    import dmem_types_pkg::*;

    logic [`DMEM_LINES-1:0] valid_q;
    tag_t tag_q [`DMEM_LINES];
    word_t data_q [`DMEM_LINES][`DMEM_LINE_WORDS];

    // Lookup is purely combinational
    assign hit_o = valid_q[lookup_index_i] && (tag_q[lookup_index_i] == lookup_tag_i);
    assign rdata_o = data_q[lookup_index_i][lookup_offset_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (fill_we_i) begin
            // Line stays invalid until its last beat lands
            valid_q[fill_index_i] <= fill_last_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            data_q[fill_index_i][fill_offset_i] <= fill_data_i;
            if (fill_last_i) begin
                tag_q[fill_index_i] <= fill_tag_i;
            end
        end else if (upd_we_i && hit_o) begin
            // Write-through store hit keeps the cached copy current
            data_q[lookup_index_i][lookup_offset_i] <= upd_data_i;
        end
    end

endmodule

// ==== rtl/store_buffer.sv ====
`timescale 1ns/10ps
`include "dmem_cfg.svh"

module store_buffer (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   push_i,
    input  dmem_types_pkg::addr_t  push_addr_i,
    input  dmem_types_pkg::word_t  push_data_i,
    input  dmem_types_pkg::addr_t  lookup_addr_i,
    output logic                   fwd_hit_o,
    output dmem_types_pkg::word_t  fwd_data_o,
    output logic                   full_o,
    output logic                   empty_o,
    output dmem_types_pkg::addr_t  head_addr_o,
    output dmem_types_pkg::word_t  head_data_o,
    input  logic                   pop_i
);
    import dmem_types_pkg::*;

    localparam int DEPTH = `DMEM_SB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    addr_t addr_q [DEPTH];
    word_t data_q [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    assign full_o = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign head_addr_o = addr_q[head_q];
    assign head_data_o = data_q[head_q];

    // New stores land at the tail
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            addr_q[tail_q] <= push_addr_i;
            data_q[tail_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // Walk oldest to youngest so the last matching entry wins
    always_comb begin
        logic [PTR_W-1:0] idx;
        fwd_hit_o = 1'b0;
        fwd_data_o = '0;
        idx = head_q;
        for (int i = 0; i < DEPTH; i++) begin
            if ((CNT_W'(i) < count_q) &&
                (addr_q[idx][`DMEM_ADDR_W-1:BYTE_OFF_W] ==
                 lookup_addr_i[`DMEM_ADDR_W-1:BYTE_OFF_W])) begin
                fwd_hit_o = 1'b1;
                fwd_data_o = data_q[idx];
            end
            idx = idx + 1'b1;
        end
    end

endmodule

// ==== rtl/miss_unit.sv ====
`timescale 1ns/10ps
`include "dmem_cfg.svh"

module miss_unit (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     fill_req_i,
    input  dmem_types_pkg::addr_t    fill_addr_i,
    output logic                     fill_done_o,
    input  logic                     sb_empty_i,
    input  dmem_types_pkg::addr_t    sb_head_addr_i,
    input  dmem_types_pkg::word_t    sb_head_data_i,
    output logic                     sb_pop_o,
    output logic                     fill_we_o,
    output dmem_types_pkg::index_t   fill_index_o,
    output dmem_types_pkg::tag_t     fill_tag_o,
    output dmem_types_pkg::offset_t  fill_offset_o,
    output dmem_types_pkg::word_t    fill_data_o,
    output logic                     fill_last_o,
    output logic                     wb_cyc_o,
    output logic                     wb_stb_o,
    output logic                     wb_we_o,
    output dmem_types_pkg::addr_t    wb_adr_o,
    output dmem_types_pkg::word_t    wb_dat_o,
    input  dmem_types_pkg::word_t    wb_dat_i,
    input  logic                     wb_ack_i
);
    import dmem_types_pkg::*;
    import dmem_ctrl_pkg::*;

    mu_state_e state_q;
    logic cyc_q;
    offset_t beat_q;
    logic beat_ack;

    assign beat_ack = cyc_q && wb_ack_i;
    assign sb_pop_o = beat_ack && (state_q == MU_DRAIN);
    assign fill_we_o = beat_ack && (state_q == MU_FILL);
    assign fill_last_o = (beat_q == '1);
    assign fill_done_o = fill_we_o && fill_last_o;
    assign fill_index_o = fill_addr_i[BYTE_OFF_W+OFFSET_W +: INDEX_W];
    assign fill_tag_o = fill_addr_i[`DMEM_ADDR_W-1 -: TAG_W];
    assign fill_offset_o = beat_q;
    assign fill_data_o = wb_dat_i;
    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;

    // Strobes drop on the edge after ack and a new cycle starts one cycle later
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= MU_IDLE;
            cyc_q <= 1'b0;
            wb_we_o <= 1'b0;
            beat_q <= '0;
        end else begin
            case (state_q)
                MU_IDLE: begin
                    beat_q <= '0;
                    // Pending stores go out before any line is read
                    if (!sb_empty_i) begin
                        state_q <= MU_DRAIN;
                    end else if (fill_req_i) begin
                        state_q <= MU_FILL;
                    end
                end
                MU_DRAIN: begin
                    if (cyc_q) begin
                        if (wb_ack_i) begin
                            cyc_q <= 1'b0;
                            wb_we_o <= 1'b0;
                        end
                    end else if (sb_empty_i) begin
                        state_q <= MU_IDLE;
                    end else begin
                        cyc_q <= 1'b1;
                        wb_we_o <= 1'b1;
                    end
                end
                MU_FILL: begin
                    if (!cyc_q) begin
                        cyc_q <= 1'b1;
                    end else if (wb_ack_i) begin
                        cyc_q <= 1'b0;
                        beat_q <= beat_q + 1'b1;
                        if (fill_last_o) begin
                            state_q <= MU_IDLE;
                        end
                    end
                end
                default: state_q <= MU_IDLE;
            endcase
        end
    end

    // Address and data load only while idle on the bus, so they hold until ack
    always_ff @(posedge clk_i) begin
        if (!cyc_q) begin
            if (state_q == MU_DRAIN) begin
                wb_adr_o <= sb_head_addr_i;
                wb_dat_o <= sb_head_data_i;
            end else begin
                wb_adr_o <= {fill_addr_i[`DMEM_ADDR_W-1:BYTE_OFF_W+OFFSET_W], beat_q,
                             {BYTE_OFF_W{1'b0}}};
            end
        end
    end

endmodule

// ==== rtl/tl_stage.sv ====
`timescale 1ns/10ps
`include "dmem_cfg.svh"

module tl_stage (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     req_valid_i,
    input  logic                     req_we_i,
    input  dmem_types_pkg::addr_t    req_addr_i,
    input  dmem_types_pkg::word_t    req_wdata_i,
    input  dmem_types_pkg::reg_t     req_rd_i,
    output logic                     resp_valid_o,
    output dmem_types_pkg::word_t    resp_rdata_o,
    output dmem_types_pkg::reg_t     resp_rd_o,
    output logic                     stall_o,
    output dmem_types_pkg::index_t   lookup_index_o,
    output dmem_types_pkg::tag_t     lookup_tag_o,
    output dmem_types_pkg::offset_t  lookup_offset_o,
    input  logic                     dc_hit_i,
    input  dmem_types_pkg::word_t    dc_rdata_i,
    output logic                     dc_upd_we_o,
    output logic                     sb_push_o,
    output dmem_types_pkg::addr_t    sb_push_addr_o,
    output dmem_types_pkg::word_t    sb_push_data_o,
    output dmem_types_pkg::addr_t    sb_lookup_addr_o,
    input  logic                     sb_fwd_hit_i,
    input  dmem_types_pkg::word_t    sb_fwd_data_i,
    input  logic                     sb_full_i,
    output logic                     fill_req_o,
    output dmem_types_pkg::addr_t    fill_addr_o,
    input  logic                     fill_done_i
);
    import dmem_types_pkg::*;
    import dmem_ctrl_pkg::*;

    tl_state_e state_q;
    tl_state_e state_d;
    addr_t miss_addr_q;
    logic load_miss;
    logic store_blocked;
    logic accept;

    assign lookup_index_o = req_addr_i[BYTE_OFF_W+OFFSET_W +: INDEX_W];
    assign lookup_tag_o = req_addr_i[`DMEM_ADDR_W-1 -: TAG_W];
    assign lookup_offset_o = req_addr_i[BYTE_OFF_W +: OFFSET_W];
    assign sb_lookup_addr_o = req_addr_i;
    assign sb_push_addr_o = req_addr_i;
    assign sb_push_data_o = req_wdata_i;

    // Hazards seen by the request in front of the stage
    assign load_miss = req_valid_i && !req_we_i && !sb_fwd_hit_i && !dc_hit_i;
    assign store_blocked = req_valid_i && req_we_i && sb_full_i;
    assign stall_o = (state_q != TL_IDLE) || load_miss || store_blocked;
    assign accept = req_valid_i && !stall_o;

    // Every store goes to the buffer, a hit also refreshes the cache
    assign sb_push_o = accept && req_we_i;
    assign dc_upd_we_o = sb_push_o && dc_hit_i;

    assign fill_req_o = (state_q == TL_MISS_WAIT);
    assign fill_addr_o = miss_addr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            TL_IDLE: begin
                if (load_miss) begin
                    state_d = TL_MISS_WAIT;
                end else if (store_blocked) begin
                    state_d = TL_SB_FULL;
                end
            end
            TL_MISS_WAIT: begin
                if (fill_done_i) begin
                    state_d = TL_IDLE;
                end
            end
            TL_SB_FULL: begin
                if (!sb_full_i) begin
                    state_d = TL_IDLE;
                end
            end
            default: state_d = TL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= TL_IDLE;
            resp_valid_o <= 1'b0;
        end else begin
            state_q <= state_d;
            resp_valid_o <= accept && !req_we_i;
        end
    end

    // Buffer data is younger than the cached copy, so it wins
    always_ff @(posedge clk_i) begin
        if (accept && !req_we_i) begin
            resp_rdata_o <= sb_fwd_hit_i ? sb_fwd_data_i : dc_rdata_i;
            resp_rd_o <= req_rd_i;
        end
        if ((state_q == TL_IDLE) && load_miss) begin
            miss_addr_q <= req_addr_i;
        end
    end

endmodule

// ==== rtl/dmem_subsystem.sv ====
`timescale 1ns/10ps

module dmem_subsystem (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   req_valid_i,
    input  logic                   req_we_i,
    input  dmem_types_pkg::addr_t  req_addr_i,
    input  dmem_types_pkg::word_t  req_wdata_i,
    input  dmem_types_pkg::reg_t   req_rd_i,
    output logic                   stall_o,
    output logic                   resp_valid_o,
    output dmem_types_pkg::word_t  resp_rdata_o,
    output dmem_types_pkg::reg_t   resp_rd_o,
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output dmem_types_pkg::addr_t  wb_adr_o,
    output dmem_types_pkg::word_t  wb_dat_o,
    input  dmem_types_pkg::word_t  wb_dat_i,
    input  logic                   wb_ack_i
);
    import dmem_types_pkg::*;

    // Lookup and store path
    index_t lookup_index;
    tag_t lookup_tag;
    offset_t lookup_offset;
    logic dc_hit;
    word_t dc_rdata;
    logic dc_upd_we;
    logic sb_push;
    addr_t sb_push_addr;
    word_t sb_push_data;
    addr_t sb_lookup_addr;
    logic sb_fwd_hit;
    word_t sb_fwd_data;
    logic sb_full;
    logic sb_empty;

    // Drain and fill path
    addr_t sb_head_addr;
    word_t sb_head_data;
    logic sb_pop;
    logic fill_req;
    addr_t fill_addr;
    logic fill_done;
    logic fill_we;
    index_t fill_index;
    tag_t fill_tag;
    offset_t fill_offset;
    word_t fill_data;
    logic fill_last;

    tl_stage u_tl_stage (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .req_valid_i      (req_valid_i),
        .req_we_i         (req_we_i),
        .req_addr_i       (req_addr_i),
        .req_wdata_i      (req_wdata_i),
        .req_rd_i         (req_rd_i),
        .resp_valid_o     (resp_valid_o),
        .resp_rdata_o     (resp_rdata_o),
        .resp_rd_o        (resp_rd_o),
        .stall_o          (stall_o),
        .lookup_index_o   (lookup_index),
        .lookup_tag_o     (lookup_tag),
        .lookup_offset_o  (lookup_offset),
        .dc_hit_i         (dc_hit),
        .dc_rdata_i       (dc_rdata),
        .dc_upd_we_o      (dc_upd_we),
        .sb_push_o        (sb_push),
        .sb_push_addr_o   (sb_push_addr),
        .sb_push_data_o   (sb_push_data),
        .sb_lookup_addr_o (sb_lookup_addr),
        .sb_fwd_hit_i     (sb_fwd_hit),
        .sb_fwd_data_i    (sb_fwd_data),
        .sb_full_i        (sb_full),
        .fill_req_o       (fill_req),
        .fill_addr_o      (fill_addr),
        .fill_done_i      (fill_done)
    );

    dcache_array u_dcache_array (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .lookup_index_i  (lookup_index),
        .lookup_tag_i    (lookup_tag),
        .lookup_offset_i (lookup_offset),
        .hit_o           (dc_hit),
        .rdata_o         (dc_rdata),
        .upd_we_i        (dc_upd_we),
        .upd_data_i      (sb_push_data),
        .fill_we_i       (fill_we),
        .fill_index_i    (fill_index),
        .fill_tag_i      (fill_tag),
        .fill_offset_i   (fill_offset),
        .fill_data_i     (fill_data),
        .fill_last_i     (fill_last)
    );

    store_buffer u_store_buffer (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .push_i        (sb_push),
        .push_addr_i   (sb_push_addr),
        .push_data_i   (sb_push_data),
        .lookup_addr_i (sb_lookup_addr),
        .fwd_hit_o     (sb_fwd_hit),
        .fwd_data_o    (sb_fwd_data),
        .full_o        (sb_full),
        .empty_o       (sb_empty),
        .head_addr_o   (sb_head_addr),
        .head_data_o   (sb_head_data),
        .pop_i         (sb_pop)
    );

    miss_unit u_miss_unit (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .fill_req_i     (fill_req),
        .fill_addr_i    (fill_addr),
        .fill_done_o    (fill_done),
        .sb_empty_i     (sb_empty),
        .sb_head_addr_i (sb_head_addr),
        .sb_head_data_i (sb_head_data),
        .sb_pop_o       (sb_pop),
        .fill_we_o      (fill_we),
        .fill_index_o   (fill_index),
        .fill_tag_o     (fill_tag),
        .fill_offset_o  (fill_offset),
        .fill_data_o    (fill_data),
        .fill_last_o    (fill_last),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_o       (wb_dat_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i)
    );

endmodule

// ==== dv/dmem_sva.sv ====
`timescale 1ns/10ps

module dmem_sva (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   req_valid_i,
    input  logic                   req_we_i,
    input  logic                   stall_o,
    input  logic                   resp_valid_o,
    input  logic                   wb_cyc_o,
    input  logic                   wb_stb_o,
    input  logic                   wb_we_o,
    input  dmem_types_pkg::addr_t  wb_adr_o,
    input  dmem_types_pkg::word_t  wb_dat_o,
    input  logic                   wb_ack_i
);

    int fail_count = 0;

    // Request phase holds address, direction and data until the slave acks
    a_wb_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_cyc_o && wb_stb_o && !wb_ack_i) |=>
            ($stable(wb_adr_o) && $stable(wb_we_o) && $stable(wb_dat_o)))
    else begin
        fail_count++;
        $error("Wishbone request changed before ack");
    end

    a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_stb_o |-> wb_cyc_o)
    else begin
        fail_count++;
        $error("wb_stb_o high outside a bus cycle");
    end

    // Strobes drop right after the ack
    a_strobe_drop: assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_cyc_o && wb_ack_i) |=> (!wb_cyc_o && !wb_stb_o))
    else begin
        fail_count++;
        $error("Wishbone strobes still high after ack");
    end

    a_resp_source: assert property (@(posedge clk_i) disable iff (reset_i)
        resp_valid_o |-> $past(req_valid_i && !req_we_i && !stall_o))
    else begin
        fail_count++;
        $error("resp_valid_o without an accepted load");
    end

    a_reset_idle: assert property (@(posedge clk_i)
        $fell(reset_i) |-> (!stall_o && !resp_valid_o && !wb_cyc_o))
    else begin
        fail_count++;
        $error("Outputs not idle in the first cycle after reset");
    end

endmodule

bind dmem_subsystem dmem_sva u_sva (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_we_i     (req_we_i),
    .stall_o      (stall_o),
    .resp_valid_o (resp_valid_o),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_i     (wb_ack_i)
);

// ==== dv/dmem_tb.sv ====
`timescale 1ns/10ps

module dmem_tb;
    import dmem_types_pkg::*;

    localparam int MEM_WORDS = 256;
    localparam int MIX_REQS = 200;
    localparam int NUM_REQS = 1 + 1 + 2 + 6 + 5 + MIX_REQS;

    logic clk_i;
    logic reset_i;
    logic req_valid_i;
    logic req_we_i;
    addr_t req_addr_i;
    word_t req_wdata_i;
    reg_t req_rd_i;
    logic stall_o;
    logic resp_valid_o;
    word_t resp_rdata_o;
    reg_t resp_rd_o;
    logic wb_cyc_o;
    logic wb_stb_o;
    logic wb_we_o;
    addr_t wb_adr_o;
    word_t wb_dat_o;
    word_t wb_dat_i;
    logic wb_ack_i;

    word_t mem [MEM_WORDS];
    word_t shadow [MEM_WORDS];
    word_t exp_load_data [$];
    reg_t exp_load_rd [$];
    addr_t exp_wr_addr [$];
    word_t exp_wr_data [$];
    int errors;
    int test_start_errors;
    int tests_done;
    int last_stall_cycles;
    int wait_left;
    logic slow_acks;

    dmem_subsystem u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        repeat (40 * NUM_REQS) @(posedge clk_i);
        $display("Watchdog expired before the tests completed");
        $display("Errors found");
        $finish;
    end

    task automatic count_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
        errors++;
    endtask

    function automatic word_t fill_pattern(input int idx);
        return 32'hc001_0000 ^ (word_t'(idx) * 32'h0001_0101);
    endfunction

    // Slave side of the bus that completes one cycle and raises ack
    task automatic complete_bus_cycle();
        int widx;
        widx = int'(wb_adr_o[9:2]);
        assert (wb_adr_o[31:10] == '0 && wb_adr_o[1:0] == '0)
        else count_error("Wishbone address outside the memory model");
        if (wb_we_o) begin
            mem[widx] = wb_dat_o;
            assert (exp_wr_addr.size() > 0)
            else count_error("Wishbone write with no pending store");
            if (exp_wr_addr.size() > 0) begin
                assert (wb_adr_o == exp_wr_addr[0])
                else report_mismatch("wb_adr_o", wb_adr_o, exp_wr_addr[0]);
                assert (wb_dat_o == exp_wr_data[0])
                else report_mismatch("wb_dat_o", wb_dat_o, exp_wr_data[0]);
                void'(exp_wr_addr.pop_front());
                void'(exp_wr_data.pop_front());
            end
        end else begin
            wb_dat_i = mem[widx];
        end
        wb_ack_i = 1'b1;
    endtask

    always @(posedge clk_i) begin
        #2;
        if (wb_ack_i) begin
            // The DUT took the ack on this edge
            wb_ack_i = 1'b0;
            wait_left = -1;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (wait_left < 0) begin
                wait_left = slow_acks ? 8 : $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                complete_bus_cycle();
            end else begin
                wait_left--;
            end
        end
    end

    always @(negedge clk_i) begin
        if (!reset_i && resp_valid_o) begin
            assert (exp_load_data.size() > 0)
            else count_error("Response without a pending load");
            if (exp_load_data.size() > 0) begin
                assert (resp_rdata_o == exp_load_data[0])
                else report_mismatch("resp_rdata_o", resp_rdata_o, exp_load_data[0]);
                assert (resp_rd_o == exp_load_rd[0])
                else report_mismatch("resp_rd_o", word_t'(resp_rd_o), word_t'(exp_load_rd[0]));
                void'(exp_load_data.pop_front());
                void'(exp_load_rd.pop_front());
            end
        end
    end

    // Called 2 ns after a rising edge and returns 2 ns after the accepting edge
    task automatic issue(input logic we, input int widx, input word_t data, input reg_t rd);
        logic accepted;
        accepted = 1'b0;
        last_stall_cycles = 0;
        req_valid_i = 1'b1;
        req_we_i = we;
        req_addr_i = addr_t'(widx) << 2;
        req_wdata_i = data;
        req_rd_i = rd;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = !stall_o;
            if (accepted && we) begin
                shadow[widx] = data;
                exp_wr_addr.push_back(req_addr_i);
                exp_wr_data.push_back(data);
            end else if (accepted) begin
                exp_load_data.push_back(shadow[widx]);
                exp_load_rd.push_back(rd);
            end else begin
                last_stall_cycles++;
            end
            @(posedge clk_i);
            #2;
        end
        req_valid_i = 1'b0;
    endtask

    task automatic wait_quiet();
        int cycles;
        cycles = 0;
        while ((exp_load_data.size() != 0 || exp_wr_addr.size() != 0 || wb_cyc_o)
               && cycles < 300) begin
            @(negedge clk_i);
            cycles++;
        end
        assert (cycles < 300)
        else count_error("DUT did not finish its pending loads and stores in time");
        @(posedge clk_i);
        #2;
    endtask

    task automatic check_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (mem[i] == shadow[i])
            else report_mismatch($sformatf("mem[%0h]", i), mem[i], shadow[i]);
        end
    endtask

    task automatic end_test(input string name);
        tests_done++;
        $display("Test %0d %s: %s", tests_done, name,
                 (errors == test_start_errors) ? "pass" : "fail");
        test_start_errors = errors;
    endtask

    initial begin
        int unsigned seed;
        int stalls;
        int widx;
        seed = 32'h9b7b_5296;
        void'($urandom(seed));
        reset_i = 1'b1;
        req_valid_i = 1'b0;
        req_we_i = 1'b0;
        req_addr_i = '0;
        req_wdata_i = '0;
        req_rd_i = '0;
        wb_dat_i = '0;
        wb_ack_i = 1'b0;
        wait_left = -1;
        slow_acks = 1'b0;
        errors = 0;
        test_start_errors = 0;
        tests_done = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_pattern(i);
            shadow[i] = fill_pattern(i);
        end
        repeat (3) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        @(negedge clk_i);
        assert (!stall_o && !resp_valid_o && !wb_cyc_o)
        else count_error("Outputs not idle right after reset");
        @(posedge clk_i);
        #2;
        issue(1'b0, 8'h45, '0, 5'd5);
        assert (last_stall_cycles > 0) else count_error("First load did not stall on a miss");
        wait_quiet();
        end_test("reset and first load miss");

        issue(1'b0, 8'h46, '0, 5'd6);
        assert (last_stall_cycles == 0) else count_error("Load to a filled line stalled");
        @(negedge clk_i);
        assert (resp_valid_o) else count_error("Hit response not one cycle after acceptance");
        wait_quiet();
        end_test("load hit latency");

        // Slow acks keep the store in the buffer while the load reads it
        // An uncached line leaves the buffer as the only source of the data
        slow_acks = 1'b1;
        issue(1'b1, 8'h23, 32'hdead_beef, '0);
        issue(1'b0, 8'h23, '0, 5'd7);
        @(negedge clk_i);
        assert (resp_valid_o) else count_error("Forwarded load gave no response");
        assert (exp_wr_addr.size() > 0)
        else count_error("Forwarded load returned after the store reached memory");
        wait_quiet();
        slow_acks = 1'b0;
        end_test("store to load forwarding");

        for (int i = 0; i < 6; i++) begin
            issue(1'b1, (i * 37 + 16) % 128, 32'h4a00_0000 + i, '0);
        end
        wait_quiet();
        check_memory();
        end_test("store write order");

        slow_acks = 1'b1;
        stalls = 0;
        for (int i = 0; i < 5; i++) begin
            issue(1'b1, 8'h30 + i, 32'h5b00_0000 + i, '0);
            stalls += last_stall_cycles;
        end
        assert (stalls > 0) else count_error("Store buffer never filled under slow acks");
        wait_quiet();
        slow_acks = 1'b0;
        check_memory();
        end_test("store buffer full");

        // Two indexes with four tags each keep lines evicting each other
        for (int i = 0; i < MIX_REQS; i++) begin
            widx = $urandom_range(3, 0) * 64 + $urandom_range(1, 0) * 4 + $urandom_range(3, 0);
            issue(1'($urandom_range(1, 0)), widx, $urandom, 5'($urandom_range(31, 0)));
        end
        wait_quiet();
        check_memory();
        end_test("random mix");

        errors = errors + u_dut.u_sva.fail_count;
        $display("Tests run: %0d, errors: %0d", tests_done, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
rtl/dmem_types_pkg.sv
rtl/dmem_ctrl_pkg.sv
rtl/dcache_array.sv
rtl/store_buffer.sv
rtl/miss_unit.sv
rtl/tl_stage.sv
rtl/dmem_subsystem.sv
dv/dmem_sva.sv
dv/dmem_tb.sv
